//--- hw/addr_route_pkg.sv
// Address router package
// Sizes, payload types, the range rule format and the state encoding
// of the address map configuration block
package addr_route_pkg;

  // Number of downstream ports
  localparam int unsigned NumPorts = 4;
  // Number of rules in the programmable address map
  localparam int unsigned NumRules = 8;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  // Ingress FIFO entries, equal to the upstream credits after reset
  localparam int unsigned IngressDepth = 4;
  // Credits held per downstream port after reset
  localparam int unsigned EgressCredits = 2;

  // Derived widths
  localparam int unsigned PortIdxWidth = $clog2(NumPorts);
  localparam int unsigned RuleNoWidth = $clog2(NumRules);
  localparam int unsigned IngressPtrWidth = $clog2(IngressDepth);
  localparam int unsigned IngressCntWidth = $clog2(IngressDepth + 1);
  localparam int unsigned CreditWidth = $clog2(EgressCredits + 1);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [PortIdxWidth-1:0] port_idx_t;
  typedef logic [RuleNoWidth-1:0] rule_no_t;

  // One range rule, start is included and end is excluded
  // An end address of zero stands for the top of the address space
  typedef struct packed {
    port_idx_t idx;
    addr_t start_addr;
    addr_t end_addr;
  } rule_t;

  // Phases of an address map rewrite
  typedef enum logic [1:0] {
    CfgIdle,
    CfgWrite,
    CfgSettle
  } cfg_state_e;

endpackage

//--- hw/route_req_if.sv
// Stage to stage request channel
// Valid/ready handshake with the request address, data word and the
// decode result, the sender holds everything stable until the transfer
interface route_req_if;

  logic valid;
  logic ready;
  addr_route_pkg::addr_t addr;
  addr_route_pkg::data_t data;
  // Decoded port and decode error, left at zero ahead of the decoder
  addr_route_pkg::port_idx_t port;
  logic dec_err;

  // Upstream stage drives the request
  modport sender (
    output valid, addr, data, port, dec_err,
    input  ready
  );

  // Downstream stage accepts it
  modport receiver (
    input  valid, addr, data, port, dec_err,
    output ready
  );

endinterface

//--- hw/addr_map_cfg.sv
// Address map configuration
// Holds the rule table of the router and its run time write port,
// and flags the rewrite so that decoding pauses until the map is stable
module addr_map_cfg (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n_i,
  input  logic                                                  cfg_we_i,
  input  addr_route_pkg::rule_no_t                              cfg_rule_no_i,
  input  addr_route_pkg::port_idx_t                             cfg_port_i,
  input  addr_route_pkg::addr_t                                 cfg_start_i,
  input  addr_route_pkg::addr_t                                 cfg_end_i,
  output addr_route_pkg::rule_t [addr_route_pkg::NumRules-1:0] addr_map_o,
  output logic                                                  cfg_ongoing_o
);
  import addr_route_pkg::*;

  rule_t [NumRules-1:0] rules_q;
  // State of the current cycle and the one registered from the last cycle
  cfg_state_e state_d;
  cfg_state_e state_q;

  // A write cycle is always CfgWrite, so the flag rises with the first write
  // The cycle after the last write is the single settle cycle
  always_comb begin
    if (cfg_we_i) begin
      state_d = CfgWrite;
    end else if (state_q == CfgWrite) begin
      state_d = CfgSettle;
    end else begin
      state_d = CfgIdle;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= CfgIdle;
    end else begin
      state_q <= state_d;
    end
  end

  assign cfg_ongoing_o = (state_d != CfgIdle);

  // Rule table, all rules empty after reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rules_q <= '0;
    end else if (cfg_we_i) begin
      rules_q[cfg_rule_no_i] <= '{idx: cfg_port_i, start_addr: cfg_start_i, end_addr: cfg_end_i};
    end
  end

  assign addr_map_o = rules_q;

  // The stored rule must describe a non-empty range once the write lands
  a_rule_ordered: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cfg_we_i |=> (rules_q[$past(cfg_rule_no_i)].start_addr <
                  rules_q[$past(cfg_rule_no_i)].end_addr) ||
                 (rules_q[$past(cfg_rule_no_i)].end_addr == '0))
    else $error("Rule written with start address not below end address");

endmodule

//--- hw/addr_decode_dync.sv
// Dynamic address decoder
// Matches an address against a table of range rules and returns the
// port of the matching rule, where the highest matching rule wins
// Unmatched addresses go to an optional default port or raise an error
// Decoding is held off while the table is being rewritten
module addr_decode_dync #(
  // Number of valid port indices, rules pointing beyond are ignored
  parameter int unsigned NoIndices = addr_route_pkg::NumPorts,
  // Number of rules in the table
  parameter int unsigned NoRules = addr_route_pkg::NumRules
) (
  input  addr_route_pkg::addr_t                addr_i,
  input  addr_route_pkg::rule_t [NoRules-1:0] addr_map_i,
  output addr_route_pkg::port_idx_t            idx_o,
  output logic                                 dec_valid_o,
  output logic                                 dec_error_o,
  input  logic                                 en_default_idx_i,
  input  addr_route_pkg::port_idx_t            default_idx_i,
  input  logic                                 config_ongoing_i
);
  import addr_route_pkg::*;

  always_comb begin
    rule_t rule;
    logic  hit;

    // No match so far, fall back to the default port or flag an error
    // A table under rewrite reports neither a decode nor an error
    dec_valid_o = 1'b0;
    dec_error_o = !en_default_idx_i && !config_ongoing_i;
    idx_o       = en_default_idx_i ? default_idx_i : '0;

    // Rules are scanned upward so a later match overrides an earlier one
    for (int unsigned i = 0; i < NoRules; i++) begin
      rule = addr_map_i[i];
      // Range check, end of zero runs to the top of the address space
      hit  = (addr_i >= rule.start_addr) &&
             ((addr_i < rule.end_addr) || (rule.end_addr == '0)) &&
             (int'(rule.idx) < int'(NoIndices));
      if (hit) begin
        dec_valid_o = !config_ongoing_i;
        dec_error_o = 1'b0;
        idx_o       = rule.idx;
      end
    end
  end

endmodule

//--- hw/route_ingress.sv
// Router ingress buffer
// FIFO for upstream requests under credit flow control, the requester
// starts with one credit per entry and gets one back per freed slot
module route_ingress (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_valid_i,
  input  addr_route_pkg::addr_t req_addr_i,
  input  addr_route_pkg::data_t req_data_i,
  output logic                  crd_o,
  route_req_if.sender           out
);
  import addr_route_pkg::*;

  addr_t addr_mem [IngressDepth];
  data_t data_mem [IngressDepth];
  logic [IngressPtrWidth-1:0] wr_ptr_q;
  logic [IngressPtrWidth-1:0] rd_ptr_q;
  logic [IngressCntWidth-1:0] count_q;
  logic push;
  logic pop;
  logic full;
  logic crd_q;

  // Every upstream request is pushed, the credit scheme keeps room for it
  assign push = req_valid_i;
  assign pop  = out.valid && out.ready;
  assign full = (count_q == IngressCntWidth'(IngressDepth));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      crd_q    <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == IngressPtrWidth'(IngressDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == IngressPtrWidth'(IngressDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!push && pop) begin
        count_q <= count_q - 1'b1;
      end
      // Slot freed at this edge goes back upstream as a credit next cycle
      crd_q <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      addr_mem[wr_ptr_q] <= req_addr_i;
      data_mem[wr_ptr_q] <= req_data_i;
    end
  end

  assign crd_o       = crd_q;
  assign out.valid   = (count_q != '0);
  assign out.addr    = addr_mem[rd_ptr_q];
  assign out.data    = data_mem[rd_ptr_q];
  // Not decoded yet
  assign out.port    = '0;
  assign out.dec_err = 1'b0;

  // A push into a full FIFO means the requester sent without a credit
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push |-> !full)
    else $error("Upstream credit violation, push into full ingress FIFO");

endmodule

//--- hw/route_decode_stage.sv
// Router decode stage
// Registers each request together with its decoded port and error flag,
// and takes no new request while the address map is being rewritten
module route_decode_stage (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n_i,
  route_req_if.receiver                                         in,
  route_req_if.sender                                           out,
  input  addr_route_pkg::rule_t [addr_route_pkg::NumRules-1:0] addr_map_i,
  input  logic                                                  cfg_ongoing_i,
  input  logic                                                  en_default_i,
  input  addr_route_pkg::port_idx_t                             default_port_i
);
  import addr_route_pkg::*;

  port_idx_t dec_port;
  logic dec_error;
  logic take;
  logic valid_q;
  addr_t addr_q;
  data_t data_q;
  port_idx_t port_q;
  logic err_q;

  addr_decode_dync #(
    .NoIndices(NumPorts),
    .NoRules  (NumRules)
  ) i_decode (
    .addr_i          (in.addr),
    .addr_map_i      (addr_map_i),
    .idx_o           (dec_port),
    .dec_valid_o     (),
    .dec_error_o     (dec_error),
    .en_default_idx_i(en_default_i),
    .default_idx_i   (default_port_i),
    .config_ongoing_i(cfg_ongoing_i)
  );

  // Accept when empty or draining, never against a half written map
  assign in.ready = !cfg_ongoing_i && (!valid_q || out.ready);
  assign take     = in.valid && in.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (out.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      addr_q <= in.addr;
      data_q <= in.data;
      port_q <= dec_port;
      err_q  <= dec_error;
    end
  end

  assign out.valid   = valid_q;
  assign out.addr    = addr_q;
  assign out.data    = data_q;
  assign out.port    = port_q;
  assign out.dec_err = err_q;

  // A stalled item keeps its payload until egress takes it
  a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out.valid && !out.ready |=> out.valid && $stable({out.addr, out.data, out.port, out.dec_err}))
    else $error("Decode stage output changed while stalled");

endmodule

//--- hw/route_egress.sv
// Router egress stage
// Sends each decoded request to its downstream port under per port
// credit flow control, and puts decode errors on a separate output
// Every captured item leaves on the next cycle, so a request is only
// taken when a credit is left for its port
module route_egress (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  route_req_if.receiver                         in,
  output logic [addr_route_pkg::NumPorts-1:0]   out_valid_o,
  output addr_route_pkg::addr_t                 out_addr_o,
  output addr_route_pkg::data_t                 out_data_o,
  input  logic [addr_route_pkg::NumPorts-1:0]   crd_i,
  output logic                                  err_valid_o,
  output addr_route_pkg::addr_t                 err_addr_o
);
  import addr_route_pkg::*;

  logic [CreditWidth-1:0] crd_cnt_q [NumPorts];
  logic [NumPorts-1:0] crd_free;
  logic take;
  logic hold_q;
  logic err_q;
  port_idx_t port_q;
  addr_t addr_q;
  data_t data_q;

  // Credits left after the send that is on the outputs this cycle
  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      crd_free[p] = (crd_cnt_q[p] > CreditWidth'(out_valid_o[p]));
    end
  end

  // Error items need no credit
  assign in.ready = in.dec_err || crd_free[in.port];
  assign take     = in.valid && in.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_q <= 1'b0;
      for (int p = 0; p < NumPorts; p++) begin
        crd_cnt_q[p] <= CreditWidth'(EgressCredits);
      end
    end else begin
      hold_q <= take;
      // Returned credits and sends can meet in one cycle
      for (int p = 0; p < NumPorts; p++) begin
        crd_cnt_q[p] <= crd_cnt_q[p] + CreditWidth'(crd_i[p]) - CreditWidth'(out_valid_o[p]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      addr_q <= in.addr;
      data_q <= in.data;
      port_q <= in.port;
      err_q  <= in.dec_err;
    end
  end

  always_comb begin
    out_valid_o = '0;
    if (hold_q && !err_q) begin
      out_valid_o[port_q] = 1'b1;
    end
  end

  assign out_addr_o  = addr_q;
  assign out_data_o  = data_q;
  assign err_valid_o = hold_q && err_q;
  assign err_addr_o  = addr_q;

  for (genvar p = 0; p < NumPorts; p++) begin : g_crd_chk
    // Downstream never returns more credits than it was given
    a_crd_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      crd_cnt_q[p] <= CreditWidth'(EgressCredits))
      else $error("Credit counter of port %0d above its reset value", p);
    // A send reserved at capture still finds its credit a cycle later
    a_send_has_crd: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_valid_o[p] |-> (crd_cnt_q[p] != '0))
      else $error("Send on port %0d without a credit", p);
  end

endmodule

//--- hw/addr_router_top.sv
// Address routed request demultiplexer
// Upstream requests pass an ingress FIFO, a registered decode against the
// run time address map and a credit controlled egress to four ports
module addr_router_top (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // Upstream requests and credits
  input  logic                                req_valid_i,
  input  addr_route_pkg::addr_t               req_addr_i,
  input  addr_route_pkg::data_t               req_data_i,
  output logic                                crd_o,
  // Address map writes
  input  logic                                cfg_we_i,
  input  addr_route_pkg::rule_no_t            cfg_rule_no_i,
  input  addr_route_pkg::port_idx_t           cfg_port_i,
  input  addr_route_pkg::addr_t               cfg_start_i,
  input  addr_route_pkg::addr_t               cfg_end_i,
  input  logic                                en_default_i,
  input  addr_route_pkg::port_idx_t           default_port_i,
  // Downstream requests, credits and decode errors
  output logic [addr_route_pkg::NumPorts-1:0] out_valid_o,
  output addr_route_pkg::addr_t               out_addr_o,
  output addr_route_pkg::data_t               out_data_o,
  input  logic [addr_route_pkg::NumPorts-1:0] crd_i,
  output logic                                err_valid_o,
  output addr_route_pkg::addr_t               err_addr_o
);
  import addr_route_pkg::*;

  rule_t [NumRules-1:0] addr_map;
  logic cfg_ongoing;

  route_req_if ing_dec ();
  route_req_if dec_egr ();

  addr_map_cfg i_cfg (
    .clk_i, .arst_n_i, .cfg_we_i, .cfg_rule_no_i, .cfg_port_i, .cfg_start_i, .cfg_end_i,
    .addr_map_o   (addr_map),
    .cfg_ongoing_o(cfg_ongoing)
  );

  route_ingress i_ingress (
    .clk_i, .arst_n_i, .req_valid_i, .req_addr_i, .req_data_i, .crd_o,
    .out(ing_dec.sender)
  );

  route_decode_stage i_decode (
    .clk_i, .arst_n_i, .en_default_i, .default_port_i,
    .in           (ing_dec.receiver),
    .out          (dec_egr.sender),
    .addr_map_i   (addr_map),
    .cfg_ongoing_i(cfg_ongoing)
  );

  route_egress i_egress (
    .clk_i, .arst_n_i, .out_valid_o, .out_addr_o, .out_data_o, .crd_i, .err_valid_o,
    .err_addr_o,
    .in(dec_egr.receiver)
  );

endmodule

//--- testbench/router_checker.sv
// Router output checker
// Compares every downstream send and every decode error with the next
// expected item in order, keeps the credit balance of each port and
// counts upstream credits against accepted requests
module router_checker (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                req_valid_i,
  input  logic                                up_crd_i,
  input  logic [addr_route_pkg::NumPorts-1:0] out_valid_i,
  input  addr_route_pkg::addr_t               out_addr_i,
  input  addr_route_pkg::data_t               out_data_i,
  input  logic [addr_route_pkg::NumPorts-1:0] dn_crd_i,
  input  logic                                err_valid_i,
  input  addr_route_pkg::addr_t               err_addr_i,
  output int                                  pending_o
);
  import addr_route_pkg::*;

  // One expected output, port and data are zero for a decode error
  typedef struct packed {
    logic      err;
    port_idx_t port;
    addr_t     addr;
    data_t     data;
  } item_t;

  item_t exp_q[$];
  string name_q[$];
  int pending = 0;
  int mismatches = 0;
  int proto_errs = 0;
  int accepted = 0;
  int returned = 0;
  // Sends on each port that still wait for their credit to come back
  int outstanding [NumPorts] = '{default: 0};

  assign pending_o = pending;

  task automatic expect_item(input string name, input logic err, input port_idx_t port,
                             input addr_t addr, input data_t data);
    item_t item;
    item.err  = err;
    item.port = err ? '0 : port;
    item.addr = addr;
    item.data = err ? '0 : data;
    exp_q.push_back(item);
    name_q.push_back(name);
    pending++;
  endtask

  always @(posedge clk_i) begin
    item_t act;
    item_t exp;
    string name;
    int hits;
    if (arst_n_i) begin
      if (req_valid_i) begin
        accepted++;
      end
      if (up_crd_i) begin
        returned++;
      end
      for (int p = 0; p < NumPorts; p++) begin
        outstanding[p] = outstanding[p] + int'(out_valid_i[p]) - int'(dn_crd_i[p]);
        if (outstanding[p] > int'(EgressCredits)) begin
          proto_errs++;
          $display("Port %0d has %0d sends without a returned credit, more than %0d allowed",
                   p, outstanding[p], EgressCredits);
        end
      end
      hits = $countones(out_valid_i) + int'(err_valid_i);
      if (hits > 1) begin
        proto_errs++;
        $display("More than one output was valid in the same cycle at time %0t", $time);
      end else if (hits == 1) begin
        // Rebuild the output in the same form as the expected item
        act      = '0;
        act.err  = err_valid_i;
        act.addr = err_valid_i ? err_addr_i : out_addr_i;
        if (!err_valid_i) begin
          act.data = out_data_i;
          for (int p = 0; p < NumPorts; p++) begin
            if (out_valid_i[p]) begin
              act.port = port_idx_t'(p);
            end
          end
        end
        if (exp_q.size() == 0) begin
          proto_errs++;
          $display("An output appeared with no request left to expect, address %h", act.addr);
        end else begin
          exp  = exp_q.pop_front();
          name = name_q.pop_front();
          pending--;
          if (act !== exp) begin
            mismatches++;
            $display("Fail %s: expected err=%0b port=%0d addr=%h data=%h, actual err=%0b %s",
                     name, exp.err, exp.port, exp.addr, exp.data, act.err,
                     $sformatf("port=%0d addr=%h data=%h", act.port, act.addr, act.data));
          end
        end
      end
    end
  end

  // End of run checks and the closing count line
  task automatic close_run(output int total);
    if (pending != 0) begin
      proto_errs++;
      $display("%0d expected outputs never appeared", pending);
    end
    if (returned != accepted) begin
      proto_errs++;
      $display("Upstream returned %0d credits for %0d accepted requests", returned, accepted);
    end
    total = mismatches + proto_errs;
    $display("Errors: %0d value mismatches, %0d protocol errors, %0d in total",
             mismatches, proto_errs, total);
  endtask

endmodule

//--- testbench/tb_addr_router.sv
// Testbench for the address router
// Programs the address map, sends requests under upstream credit flow
// control, returns downstream credits with random gaps and hands the
// expected route of every accepted request to the checker
module tb_addr_router;
  import addr_route_pkg::*;

  // Requests sent by all phases together, sizes the watchdog
  localparam int PlannedReqs = 92;
  localparam int TimeoutCycles = 2000 + 20 * PlannedReqs;

  logic clk_i = 1'b0;
  logic arst_n_i;
  logic req_valid_i;
  addr_t req_addr_i;
  data_t req_data_i;
  logic crd_o;
  logic cfg_we_i;
  rule_no_t cfg_rule_no_i;
  port_idx_t cfg_port_i;
  addr_t cfg_start_i;
  addr_t cfg_end_i;
  logic en_default_i;
  port_idx_t default_port_i;
  logic [NumPorts-1:0] out_valid_o;
  addr_t out_addr_o;
  data_t out_data_o;
  logic [NumPorts-1:0] crd_i = '0;
  logic err_valid_o;
  addr_t err_addr_o;

  int pending;
  int errs;
  // Upstream credit accounting, requests sent and crd_o pulses seen
  int sent = 0;
  int crd_seen = 0;
  // Withholds all downstream credits while set
  logic hold_crd = 1'b0;
  int outst [NumPorts] = '{default: 0};
  // Copy of the rule table as written into the DUT
  port_idx_t rule_port [NumRules];
  addr_t rule_start [NumRules];
  addr_t rule_end [NumRules];

  addr_router_top dut (.*);

  router_checker chk (
    .clk_i, .arst_n_i, .req_valid_i,
    .up_crd_i   (crd_o),
    .out_valid_i(out_valid_o),
    .out_addr_i (out_addr_o),
    .out_data_i (out_data_o),
    .dn_crd_i   (crd_i),
    .err_valid_i(err_valid_o),
    .err_addr_i (err_addr_o),
    .pending_o  (pending)
  );

  always #2 clk_i = ~clk_i;

  // Counted mid cycle so the sender sees a settled total at the edge
  always @(negedge clk_i) begin
    if (crd_o) begin
      crd_seen++;
    end
  end

  // Each send is owed one credit, returned after a random gap
  always @(posedge clk_i) begin
    for (int p = 0; p < NumPorts; p++) begin
      outst[p] = outst[p] + int'(out_valid_o[p]) - int'(crd_i[p]);
      crd_i[p] <= !hold_crd && (outst[p] > 0) && ($urandom_range(0, 2) != 0);
    end
  end

  // Expected {error, port}, the first match from the top rule down wins
  function automatic logic [PortIdxWidth:0] ref_decode(input addr_t a);
    for (int i = NumRules - 1; i >= 0; i--) begin
      if ((a >= rule_start[i]) && ((rule_end[i] == '0) || (a < rule_end[i]))) begin
        return {1'b0, rule_port[i]};
      end
    end
    if (en_default_i) begin
      return {1'b0, default_port_i};
    end
    return {1'b1, port_idx_t'(0)};
  endfunction

  // Mostly mapped addresses in the low part of the map
  function automatic addr_t low_addr();
    return addr_t'($urandom_range(0, 32'h0000_6fff));
  endfunction

  task automatic set_rule(input int i, input port_idx_t port, input addr_t s, input addr_t e);
    rule_port[i]  = port;
    rule_start[i] = s;
    rule_end[i]   = e;
  endtask

  // Writes one rule from the copy, consecutive calls keep cfg_we_i high
  task automatic drive_rule(input int i);
    @(posedge clk_i);
    cfg_we_i      <= 1'b1;
    cfg_rule_no_i <= rule_no_t'(i);
    cfg_port_i    <= rule_port[i];
    cfg_start_i   <= rule_start[i];
    cfg_end_i     <= rule_end[i];
  endtask

  task automatic end_cfg();
    @(posedge clk_i);
    cfg_we_i <= 1'b0;
  endtask

  // One request per held credit, the expected route is taken at acceptance
  task automatic send_req(input string name, input addr_t a);
    data_t d;
    logic [PortIdxWidth:0] exp;
    d = $urandom();
    @(posedge clk_i);
    while (int'(IngressDepth) + crd_seen - sent <= 0) begin
      req_valid_i <= 1'b0;
      @(posedge clk_i);
    end
    req_valid_i <= 1'b1;
    req_addr_i  <= a;
    req_data_i  <= d;
    sent++;
    exp = ref_decode(a);
    chk.expect_item(name, exp[PortIdxWidth], exp[PortIdxWidth-1:0], a, d);
  endtask

  // Waits until every expected item has come out
  task automatic wait_quiet();
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    while (pending != 0) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  // Holes in the map at both ends and between the rules, then random ones
  task automatic unmapped_phase(input string name);
    send_req(name, 32'h0000_0000);
    send_req(name, 32'h0000_0fff);
    send_req(name, 32'h0000_4000);
    send_req(name, 32'h7fff_ffff);
    for (int n = 0; n < 12; n++) begin
      send_req(name, $urandom());
    end
    wait_quiet();
  endtask

  initial begin
    addr_t last;
    void'($urandom(92));
    arst_n_i       = 1'b0;
    req_valid_i    = 1'b0;
    req_addr_i     = '0;
    req_data_i     = '0;
    cfg_we_i       = 1'b0;
    cfg_rule_no_i  = '0;
    cfg_port_i     = '0;
    cfg_start_i    = '0;
    cfg_end_i      = '0;
    en_default_i   = 1'b0;
    default_port_i = '0;
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // Rules 3, 5 and 6 sit inside lower rules with other ports
    set_rule(0, 2'd0, 32'h0000_1000, 32'h0000_2000);
    set_rule(1, 2'd1, 32'h0000_2000, 32'h0000_3000);
    set_rule(2, 2'd2, 32'h0000_3000, 32'h0000_4000);
    set_rule(3, 2'd3, 32'h0000_1800, 32'h0000_1900);
    set_rule(4, 2'd2, 32'h8000_0000, 32'h0000_0000);
    set_rule(5, 2'd3, 32'h0000_2800, 32'h0000_2900);
    set_rule(6, 2'd1, 32'h0000_1080, 32'h0000_10c0);
    set_rule(7, 2'd0, 32'h0000_5000, 32'h0000_6000);
    for (int i = 0; i < NumRules; i++) begin
      drive_rule(i);
    end
    end_cfg();

    // Start, middle and last address of every rule
    for (int i = 0; i < NumRules; i++) begin
      last = (rule_end[i] == '0) ? '1 : rule_end[i] - 1;
      send_req("range", rule_start[i]);
      send_req("range", rule_start[i] + ((last - rule_start[i]) >> 1));
      send_req("range", last);
    end
    wait_quiet();

    unmapped_phase("no_default");
    en_default_i   <= 1'b1;
    default_port_i <= 2'd1;
    unmapped_phase("default");

    // Credits come back only after the pipeline and the FIFO have filled up
    hold_crd <= 1'b1;
    fork
      for (int n = 0; n < 24; n++) begin
        send_req("backpressure", low_addr());
      end
      begin
        repeat (100) @(posedge clk_i);
        hold_crd <= 1'b0;
      end
    join
    wait_quiet();

    // New map written back to back while requests keep arriving
    set_rule(0, 2'd2, 32'h0000_1000, 32'h0000_2000);
    set_rule(1, 2'd0, 32'h0000_2000, 32'h0000_4000);
    set_rule(4, 2'd1, 32'h4000_0000, 32'h0000_0000);
    set_rule(7, 2'd3, 32'h0000_0000, 32'h0000_0800);
    fork
      begin
        drive_rule(0);
        drive_rule(1);
        drive_rule(4);
        drive_rule(7);
        end_cfg();
      end
      for (int n = 0; n < 6; n++) begin
        send_req("reconfig", low_addr());
        send_req("reconfig", $urandom());
      end
    join
    wait_quiet();

    chk.close_run(errs);
    if (errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    int wd_errs;
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Timeout, the run did not complete within %0d cycles", TimeoutCycles);
    chk.close_run(wd_errs);
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- all.f
hw/addr_route_pkg.sv
hw/route_req_if.sv
hw/addr_map_cfg.sv
hw/addr_decode_dync.sv
hw/route_ingress.sv
hw/route_decode_stage.sv
hw/route_egress.sv
hw/addr_router_top.sv
testbench/router_checker.sv
testbench/tb_addr_router.sv

//--- Bender.yml
package:
  name: addr_router

sources:
  - files:
      - hw/addr_route_pkg.sv
      - hw/route_req_if.sv
      - hw/addr_map_cfg.sv
      - hw/addr_decode_dync.sv
      - hw/route_ingress.sv
      - hw/route_decode_stage.sv
      - hw/route_egress.sv
      - hw/addr_router_top.sv
  - target: test
    files:
      - testbench/router_checker.sv
      - testbench/tb_addr_router.sv
